// File: rtl/glbl_pkg.sv
/*
  Global register package
  Shared widths, register offsets, reset values and bus structs
  for the SoC global register block
*/
`default_nettype none

package glbl_pkg;

  // --------------------------------------------------
  // Basic widths
  // --------------------------------------------------
  typedef logic [3:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;
  // One enable per byte lane
  typedef logic [3:0]  reg_be_t;

  // --------------------------------------------------
  // Register offsets
  // --------------------------------------------------
  localparam reg_addr_t ADDR_CHIP_ID   = 4'h0;
  localparam reg_addr_t ADDR_GLBL_CFG  = 4'h1;
  localparam reg_addr_t ADDR_INTR_MASK = 4'h2;
  localparam reg_addr_t ADDR_INTR_STAT = 4'h3;
  localparam reg_addr_t ADDR_MUX_SEL   = 4'h4;
  localparam reg_addr_t ADDR_SW_REG0   = 4'h5;
  localparam reg_addr_t ADDR_SW_REG1   = 4'h6;

  // Chip ID fields, ASCII "RD" manufacturer code
  localparam logic [15:0] MANU_ID    = 16'h8268;
  localparam logic [3:0]  TOTAL_CORE = 4'h4;

  // Scratch register reset values
  localparam reg_data_t SW_REG0_INIT = 32'h8273_8343;
  localparam reg_data_t SW_REG1_INIT = 32'h0005_0000;

  // --------------------------------------------------
  // Reset control bit positions
  // --------------------------------------------------
  localparam int RST_CPU_INTF_BIT = 0;
  localparam int RST_QSPIM_BIT    = 1;
  localparam int RST_SSPIM_BIT    = 2;
  localparam int RST_UART0_BIT    = 3;
  localparam int RST_I2CM_BIT     = 4;
  localparam int RST_USB_BIT      = 5;
  localparam int RST_UART1_BIT    = 6;
  localparam int RST_CPU_CORE_LSB = 8;
  localparam int RST_CPU_CORE_MSB = 11;

  // Single-cycle write request to the register blocks
  typedef struct packed {
    logic      wr;
    reg_addr_t addr;
    reg_data_t wdata;
    reg_be_t   be;
  } glbl_req_t;

  // Hardware interrupt sources, msb first
  typedef struct packed {
    logic       gpio;
    logic [1:0] ext;
    logic       usb;
    logic       i2cm;
    logic [2:0] timer;
  } hw_intr_t;

  // Active-low block resets
  typedef struct packed {
    logic [3:0] cpu_core;
    logic       usb;
    logic [1:0] uart;
    logic       i2cm;
    logic       sspim;
    logic       qspim;
    logic       cpu_intf;
  } blk_rst_t;

  // Byte-lane merge of write data into a register value
  function automatic reg_data_t be_merge(input reg_data_t cur,
                                         input reg_data_t wdata,
                                         input reg_be_t   be);
    reg_data_t res;
    res = cur;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) res[i*8 +: 8] = wdata[i*8 +: 8];
    end
    return res;
  endfunction

endpackage

`default_nettype wire

// File: rtl/glbl_bus_if.sv
/*
  Global register bus front end
  Builds the one-cycle write request, the acknowledge strobe
  and the captured read data from the two register blocks
*/
`timescale 1ns/1ps
`default_nettype none

module glbl_bus_if (
  input  wire                    mclk,
  input  wire                    h_reset_n,

  // Register bus from the master
  input  wire                    reg_cs,
  input  wire                    reg_wr,
  input  wire glbl_pkg::reg_addr_t reg_addr,
  input  wire glbl_pkg::reg_data_t reg_wdata,
  input  wire glbl_pkg::reg_be_t   reg_be,

  // Read data from the register blocks
  input  wire glbl_pkg::reg_data_t cfg_rdata,
  input  wire glbl_pkg::reg_data_t intr_rdata,

  // Request to the register blocks
  output glbl_pkg::glbl_req_t    req,

  // Bus response
  output glbl_pkg::reg_data_t    reg_rdata,
  output logic                   reg_ack
);

  // --------------------------------------------------
  // Access qualifiers
  // --------------------------------------------------

  // New access starts when selected and not yet acked
  logic acc_start;
  glbl_pkg::reg_data_t rd_mux;

  assign acc_start = reg_cs & ~reg_ack;

  // Unmapped offsets read zero from both blocks
  assign rd_mux = cfg_rdata | intr_rdata;

  // Write strobe only in the cycle before the ack edge
  always_comb begin
    req.wr    = acc_start & reg_wr;
    req.addr  = reg_addr;
    req.wdata = reg_wdata;
    req.be    = reg_be;
  end

  // --------------------------------------------------
  // Ack and read data capture
  // --------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      reg_ack   <= 1'b0;
      reg_rdata <= '0;
    end else if (acc_start) begin
      // Pre-write value of this access
      reg_rdata <= rd_mux;
      reg_ack   <= 1'b1;
    end else begin
      reg_ack   <= 1'b0;
    end
  end

  // Ack is a single-cycle pulse per access
  a_ack_single: assert property (
    @(posedge mclk) disable iff (!h_reset_n)
    reg_ack |=> !reg_ack
  ) else $error("reg_ack high on two consecutive cycles");

endmodule

`default_nettype wire

// File: rtl/glbl_cfg_regs.sv
/*
  Global configuration registers
  Read-only chip ID, block reset control, pin select and two
  software scratch registers with byte-lane writes
*/
`timescale 1ns/1ps
`default_nettype none

module glbl_cfg_regs #(
  parameter logic [3:0] CHIP_ID  = 4'h5,
  parameter logic [7:0] CHIP_REV = 8'h01
) (
  input  wire                      mclk,
  input  wire                      h_reset_n,
  input  wire glbl_pkg::glbl_req_t req,

  output glbl_pkg::reg_data_t      rdata,
  output glbl_pkg::blk_rst_t       blk_rst_n,
  output glbl_pkg::reg_data_t      mux_sel
);

  // --------------------------------------------------
  // Register storage
  // --------------------------------------------------
  glbl_pkg::reg_data_t chip_id_word;
  glbl_pkg::reg_data_t glbl_cfg_q;
  glbl_pkg::reg_data_t mux_sel_q;
  glbl_pkg::reg_data_t sw_reg0_q;
  glbl_pkg::reg_data_t sw_reg1_q;

  // Per-register write strobes
  logic wr_glbl_cfg;
  logic wr_mux_sel;
  logic wr_sw_reg0;
  logic wr_sw_reg1;

  // Fixed ID word, manufacturer in the upper half
  assign chip_id_word = {glbl_pkg::MANU_ID, glbl_pkg::TOTAL_CORE, CHIP_ID, CHIP_REV};

  assign wr_glbl_cfg = req.wr && (req.addr == glbl_pkg::ADDR_GLBL_CFG);
  assign wr_mux_sel  = req.wr && (req.addr == glbl_pkg::ADDR_MUX_SEL);
  assign wr_sw_reg0  = req.wr && (req.addr == glbl_pkg::ADDR_SW_REG0);
  assign wr_sw_reg1  = req.wr && (req.addr == glbl_pkg::ADDR_SW_REG1);

  // All blocks held in reset until software releases them
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      glbl_cfg_q <= '0;
      mux_sel_q  <= '0;
      sw_reg0_q  <= glbl_pkg::SW_REG0_INIT;
      sw_reg1_q  <= glbl_pkg::SW_REG1_INIT;
    end else begin
      if (wr_glbl_cfg) glbl_cfg_q <= glbl_pkg::be_merge(glbl_cfg_q, req.wdata, req.be);
      if (wr_mux_sel)  mux_sel_q  <= glbl_pkg::be_merge(mux_sel_q, req.wdata, req.be);
      if (wr_sw_reg0)  sw_reg0_q  <= glbl_pkg::be_merge(sw_reg0_q, req.wdata, req.be);
      if (wr_sw_reg1)  sw_reg1_q  <= glbl_pkg::be_merge(sw_reg1_q, req.wdata, req.be);
    end
  end

  // --------------------------------------------------
  // Reset outputs
  // --------------------------------------------------
  always_comb begin
    blk_rst_n.cpu_intf = glbl_cfg_q[glbl_pkg::RST_CPU_INTF_BIT];
    blk_rst_n.qspim    = glbl_cfg_q[glbl_pkg::RST_QSPIM_BIT];
    blk_rst_n.sspim    = glbl_cfg_q[glbl_pkg::RST_SSPIM_BIT];
    blk_rst_n.uart[0]  = glbl_cfg_q[glbl_pkg::RST_UART0_BIT];
    blk_rst_n.i2cm     = glbl_cfg_q[glbl_pkg::RST_I2CM_BIT];
    blk_rst_n.usb      = glbl_cfg_q[glbl_pkg::RST_USB_BIT];
    blk_rst_n.uart[1]  = glbl_cfg_q[glbl_pkg::RST_UART1_BIT];
    // Four core resets from one nibble
    blk_rst_n.cpu_core = glbl_cfg_q[glbl_pkg::RST_CPU_CORE_MSB:glbl_pkg::RST_CPU_CORE_LSB];
  end

  // Multi-function pin select straight from the register
  assign mux_sel = mux_sel_q;

  // --------------------------------------------------
  // Read data
  // --------------------------------------------------
  always_comb begin
    case (req.addr)
      glbl_pkg::ADDR_CHIP_ID:  rdata = chip_id_word;
      glbl_pkg::ADDR_GLBL_CFG: rdata = glbl_cfg_q;
      glbl_pkg::ADDR_MUX_SEL:  rdata = mux_sel_q;
      glbl_pkg::ADDR_SW_REG0:  rdata = sw_reg0_q;
      glbl_pkg::ADDR_SW_REG1:  rdata = sw_reg1_q;
      // Other offsets belong to the interrupt block or are unmapped
      default:                 rdata = '0;
    endcase
  end

  // Chip ID survives a write to its own offset
  a_chip_id_ro: assert property (
    @(posedge mclk) disable iff (!h_reset_n)
    (req.wr && (req.addr == glbl_pkg::ADDR_CHIP_ID)) ##1
      (req.addr == glbl_pkg::ADDR_CHIP_ID) |-> $stable(rdata)
  ) else $error("chip ID read value changed by a write");

endmodule

`default_nettype wire

// File: rtl/glbl_intr_ctrl.sv
/*
  Global interrupt controller
  Mask and status registers with sticky hardware bits and
  the masked interrupt lines towards the core
*/
`timescale 1ns/1ps
`default_nettype none

module glbl_intr_ctrl (
  input  wire                      mclk,
  input  wire                      h_reset_n,
  input  wire glbl_pkg::glbl_req_t req,
  input  wire glbl_pkg::hw_intr_t  hw_intr,

  output glbl_pkg::reg_data_t      rdata,
  output logic [15:0]              irq_lines,
  output logic                     soft_irq,
  output logic [2:0]               user_irq
);

  // --------------------------------------------------
  // Decode and next state
  // --------------------------------------------------
  logic                wr_mask;
  logic                wr_stat;
  logic [19:0]         mask_q;
  logic [19:0]         stat_q;
  glbl_pkg::reg_data_t mask_nxt;
  glbl_pkg::reg_data_t stat_wr;
  logic [7:0]          hw_req;
  logic [7:0]          hw_clr;
  logic [7:0]          hw_nxt;
  logic [19:0]         irq_word;

  assign wr_mask = req.wr && (req.addr == glbl_pkg::ADDR_INTR_MASK);
  assign wr_stat = req.wr && (req.addr == glbl_pkg::ADDR_INTR_STAT);

  // Flatten the source struct into status bits 15:8
  assign hw_req = hw_intr;

  // Mask bits above 19 are not stored
  assign mask_nxt = glbl_pkg::be_merge({12'h0, mask_q}, req.wdata, req.be);

  // Plain lanes of status, lane 1 overridden below
  assign stat_wr = glbl_pkg::be_merge({12'h0, stat_q}, req.wdata, req.be);

  // Write one to clear, only with lane 1 enabled
  assign hw_clr = (wr_stat && req.be[1]) ? req.wdata[15:8] : 8'h00;

  // Hardware request wins over a clear in the same cycle
  assign hw_nxt = hw_req | (stat_q[15:8] & ~hw_clr);

  // --------------------------------------------------
  // Mask and status registers
  // --------------------------------------------------
  always_ff @(posedge mclk or negedge h_reset_n) begin
    if (!h_reset_n) begin
      mask_q <= '0;
      stat_q <= '0;
    end else begin
      if (wr_mask) mask_q <= mask_nxt[19:0];
      // Software bits 7:0 and 19:16
      if (wr_stat) begin
        stat_q[7:0]   <= stat_wr[7:0];
        stat_q[19:16] <= stat_wr[19:16];
      end
      // Sticky hardware bits latch every cycle
      stat_q[15:8] <= hw_nxt;
    end
  end

  // --------------------------------------------------
  // Interrupt outputs
  // --------------------------------------------------
  assign irq_word  = mask_q & stat_q;
  assign irq_lines = irq_word[15:0];
  assign soft_irq  = irq_word[16];
  assign user_irq  = irq_word[19:17];

  // Read data for own offsets only
  always_comb begin
    case (req.addr)
      glbl_pkg::ADDR_INTR_MASK: rdata = {12'h0, mask_q};
      glbl_pkg::ADDR_INTR_STAT: rdata = {12'h0, stat_q};
      default:                  rdata = '0;
    endcase
  end

  // Every active hardware request shows up in status next cycle
  a_hw_latch: assert property (
    @(posedge mclk) disable iff (!h_reset_n)
    (hw_req != 8'h00) |=> ((stat_q[15:8] & $past(hw_req)) == $past(hw_req))
  ) else $error("hardware interrupt request not latched in status");

endmodule

`default_nettype wire

// File: rtl/glbl_reg_top.sv
/*
  Global register block top level
  Bus front end beside the configuration and interrupt
  register blocks
*/
`timescale 1ns/1ps
`default_nettype none

module glbl_reg_top #(
  parameter logic [3:0] CHIP_ID  = 4'h5,
  parameter logic [7:0] CHIP_REV = 8'h01
) (
  input  wire                      mclk,
  input  wire                      h_reset_n,

  // --------------------------------------------------
  // Register bus
  // --------------------------------------------------
  input  wire                      reg_cs,
  input  wire                      reg_wr,
  input  wire glbl_pkg::reg_addr_t reg_addr,
  input  wire glbl_pkg::reg_data_t reg_wdata,
  input  wire glbl_pkg::reg_be_t   reg_be,
  output glbl_pkg::reg_data_t      reg_rdata,
  output logic                     reg_ack,

  // Hardware interrupt sources
  input  wire glbl_pkg::hw_intr_t  hw_intr,

  // Block resets and pin muxing
  output glbl_pkg::blk_rst_t       blk_rst_n,
  output glbl_pkg::reg_data_t      mux_sel,

  // Interrupts to the core
  output logic [15:0]              irq_lines,
  output logic                     soft_irq,
  output logic [2:0]               user_irq
);

  // Internal request and read data
  glbl_pkg::glbl_req_t reg_req;
  glbl_pkg::reg_data_t cfg_rdata;
  glbl_pkg::reg_data_t intr_rdata;

  // Bus front end
  glbl_bus_if u_bus_if (
    .mclk       (mclk),
    .h_reset_n  (h_reset_n),
    .reg_cs     (reg_cs),
    .reg_wr     (reg_wr),
    .reg_addr   (reg_addr),
    .reg_wdata  (reg_wdata),
    .reg_be     (reg_be),
    .cfg_rdata  (cfg_rdata),
    .intr_rdata (intr_rdata),
    .req        (reg_req),
    .reg_rdata  (reg_rdata),
    .reg_ack    (reg_ack)
  );

  // Chip ID, reset control, pin select, scratch
  glbl_cfg_regs #(
    .CHIP_ID  (CHIP_ID),
    .CHIP_REV (CHIP_REV)
  ) u_cfg_regs (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .req       (reg_req),
    .rdata     (cfg_rdata),
    .blk_rst_n (blk_rst_n),
    .mux_sel   (mux_sel)
  );

  // Interrupt mask and status
  glbl_intr_ctrl u_intr_ctrl (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .req       (reg_req),
    .hw_intr   (hw_intr),
    .rdata     (intr_rdata),
    .irq_lines (irq_lines),
    .soft_irq  (soft_irq),
    .user_irq  (user_irq)
  );

endmodule

`default_nettype wire

// File: verification/tb_glbl_reg_table.svh
/*
  Stimulus table for the global register testbench
  Columns: hw pulse, write, offset, byte enables, write data,
  expected rdata, expected blk_rst_n, expected irq word, check flags
*/
`ifndef TB_GLBL_REG_TABLE_SVH
`define TB_GLBL_REG_TABLE_SVH
`default_nettype none

  task automatic load_steps();
    // Reset values
    add_step(8'h00, 1'b0, 4'h0, 4'hF, 32'h0000_0000, 32'h8268_4501, 11'h000, 20'h00000, 3'b111);
    add_step(8'h00, 1'b0, 4'h5, 4'hF, 32'h0000_0000, 32'h8273_8343, 11'h000, 20'h00000, 3'b100);
    add_step(8'h00, 1'b0, 4'h6, 4'hF, 32'h0000_0000, 32'h0005_0000, 11'h000, 20'h00000, 3'b100);
    add_step(8'h00, 1'b0, 4'h4, 4'hF, 32'h0000_0000, 32'h0000_0000, 11'h000, 20'h00000, 3'b100);
    // Reset control, full then partial lanes
    add_step(8'h00, 1'b1, 4'h1, 4'hF, 32'h0000_0F7F, 32'h0000_0000, 11'h7FF, 20'h00000, 3'b110);
    add_step(8'h00, 1'b1, 4'h1, 4'h2, 32'hFFFF_0500, 32'h0000_0F7F, 11'h2FF, 20'h00000, 3'b110);
    add_step(8'h00, 1'b1, 4'h1, 4'h1, 32'h0000_0A2D, 32'h0000_057F, 11'h2D5, 20'h00000, 3'b110);
    add_step(8'h00, 1'b0, 4'h1, 4'hF, 32'h0000_0000, 32'h0000_052D, 11'h2D5, 20'h00000, 3'b110);
    // Pin select and scratch lanes
    add_step(8'h00, 1'b1, 4'h4, 4'hF, 32'h1234_5678, 32'h0000_0000, 11'h2D5, 20'h00000, 3'b100);
    add_step(8'h00, 1'b1, 4'h4, 4'hA, 32'hAABB_CCDD, 32'h1234_5678, 11'h2D5, 20'h00000, 3'b100);
    add_step(8'h00, 1'b0, 4'h4, 4'hF, 32'h0000_0000, 32'hAA34_CC78, 11'h2D5, 20'h00000, 3'b100);
    add_step(8'h00, 1'b1, 4'h5, 4'h1, 32'h0000_00FF, 32'h8273_8343, 11'h2D5, 20'h00000, 3'b100);
    add_step(8'h00, 1'b1, 4'h6, 4'hC, 32'hDEAD_BEEF, 32'h0005_0000, 11'h2D5, 20'h00000, 3'b100);
    add_step(8'h00, 1'b0, 4'h5, 4'hF, 32'h0000_0000, 32'h8273_83FF, 11'h2D5, 20'h00000, 3'b100);
    add_step(8'h00, 1'b0, 4'h6, 4'hF, 32'h0000_0000, 32'hDEAD_0000, 11'h2D5, 20'h00000, 3'b100);
    // Chip ID is read-only, offset 9 is unmapped
    add_step(8'h00, 1'b1, 4'h0, 4'hF, 32'hFFFF_FFFF, 32'h8268_4501, 11'h2D5, 20'h00000, 3'b100);
    add_step(8'h00, 1'b0, 4'h9, 4'hF, 32'h0000_0000, 32'h0000_0000, 11'h2D5, 20'h00000, 3'b100);
    add_step(8'h00, 1'b0, 4'h0, 4'hF, 32'h0000_0000, 32'h8268_4501, 11'h2D5, 20'h00000, 3'b110);
    // usb pulse lands in status bit 12
    add_step(8'h10, 1'b0, 4'h3, 4'hF, 32'h0000_0000, 32'h0000_1000, 11'h000, 20'h00000, 3'b101);
    add_step(8'h00, 1'b1, 4'h2, 4'hF, 32'h0000_1000, 32'h0000_0000, 11'h000, 20'h01000, 3'b101);
    add_step(8'h00, 1'b1, 4'h3, 4'h2, 32'h0000_0000, 32'h0000_1000, 11'h000, 20'h01000, 3'b101);
    add_step(8'h00, 1'b1, 4'h3, 4'h2, 32'h0000_1000, 32'h0000_1000, 11'h000, 20'h00000, 3'b101);
    add_step(8'h00, 1'b0, 4'h3, 4'hF, 32'h0000_0000, 32'h0000_0000, 11'h000, 20'h00000, 3'b101);
    // Software and user interrupt bits
    add_step(8'h00, 1'b1, 4'h3, 4'h4, 32'h000F_0000, 32'h0000_0000, 11'h000, 20'h00000, 3'b101);
    add_step(8'h00, 1'b1, 4'h2, 4'h4, 32'h0005_0000, 32'h0000_1000, 11'h000, 20'h50000, 3'b101);
    add_step(8'h00, 1'b1, 4'h2, 4'h4, 32'h000E_0000, 32'h0005_1000, 11'h000, 20'hE0000, 3'b101);
    add_step(8'h00, 1'b1, 4'h2, 4'h4, 32'h0004_0000, 32'h000E_1000, 11'h000, 20'h40000, 3'b101);
    add_step(8'h00, 1'b0, 4'h3, 4'hF, 32'h0000_0000, 32'h000F_0000, 11'h000, 20'h40000, 3'b101);
    add_step(8'h00, 1'b1, 4'h3, 4'h4, 32'h0000_0000, 32'h000F_0000, 11'h000, 20'h00000, 3'b101);
  endtask

`default_nettype wire
`endif

// File: verification/tb_glbl_reg.sv
/*
  Global register block testbench
  Runs a table of bus accesses and interrupt pulses through the DUT
  and checks read data, block resets and interrupt outputs
*/
`timescale 1ns/1ps
`default_nettype none

module tb_glbl_reg;

  // One table step: stimulus, expected values, check enables
  typedef struct packed {
    logic [7:0]          hw;
    logic                wr;
    glbl_pkg::reg_addr_t addr;
    glbl_pkg::reg_be_t   be;
    glbl_pkg::reg_data_t wdata;
    glbl_pkg::reg_data_t exp_rdata;
    glbl_pkg::blk_rst_t  exp_rst;
    logic [19:0]         exp_irq;
    // rdata, blk_rst_n, irq word
    logic [2:0]          chk;
  } step_t;

  logic                mclk;
  logic                h_reset_n;
  logic                reg_cs;
  logic                reg_wr;
  glbl_pkg::reg_addr_t reg_addr;
  glbl_pkg::reg_data_t reg_wdata;
  glbl_pkg::reg_be_t   reg_be;
  glbl_pkg::reg_data_t reg_rdata;
  logic                reg_ack;
  glbl_pkg::hw_intr_t  hw_intr;
  glbl_pkg::blk_rst_t  blk_rst_n;
  glbl_pkg::reg_data_t mux_sel;
  logic [15:0]         irq_lines;
  logic                soft_irq;
  logic [2:0]          user_irq;

  step_t steps[$];
  int    errors;
  int    checks;

  glbl_reg_top #(
    .CHIP_ID  (4'h5),
    .CHIP_REV (8'h01)
  ) i_dut (
    .mclk      (mclk),
    .h_reset_n (h_reset_n),
    .reg_cs    (reg_cs),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_be    (reg_be),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .hw_intr   (hw_intr),
    .blk_rst_n (blk_rst_n),
    .mux_sel   (mux_sel),
    .irq_lines (irq_lines),
    .soft_irq  (soft_irq),
    .user_irq  (user_irq)
  );

  // 40 ns clock
  initial begin
    mclk = 1'b0;
    forever #20 mclk = ~mclk;
  end

  task automatic add_step(input logic [7:0] hw, input logic wr,
                          input logic [3:0] addr, input logic [3:0] be,
                          input logic [31:0] wdata, input logic [31:0] exp_rdata,
                          input logic [10:0] exp_rst, input logic [19:0] exp_irq,
                          input logic [2:0] chk);
    step_t s;
    s = {hw, wr, addr, be, wdata, exp_rdata, exp_rst, exp_irq, chk};
    steps.push_back(s);
  endtask

`include "tb_glbl_reg_table.svh"

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    step_t s;
    int    cycles;
    bit    got_ack;
    bit    timed_out;
    errors    = 0;
    checks    = 0;
    timed_out = 0;
    h_reset_n = 1'b0;
    reg_cs    = 1'b0;
    reg_wr    = 1'b0;
    reg_addr  = '0;
    reg_wdata = '0;
    reg_be    = '0;
    hw_intr   = '0;
    load_steps();
    repeat (4) @(posedge mclk);
    h_reset_n <= 1'b1;

    for (int i = 0; i < steps.size() && !timed_out; i++) begin
      s = steps[i];
      // Interrupt pulse high for exactly one rising edge
      @(posedge mclk);
      hw_intr <= s.hw;
      @(posedge mclk);
      hw_intr   <= '0;
      reg_cs    <= 1'b1;
      reg_wr    <= s.wr;
      reg_addr  <= s.addr;
      reg_wdata <= s.wdata;
      reg_be    <= s.be;
      // Ack sampled mid-cycle
      cycles  = 0;
      got_ack = 0;
      while (!got_ack && cycles < 20) begin
        @(negedge mclk);
        cycles++;
        if (reg_ack) got_ack = 1;
      end
      if (!got_ack) begin
        $display("No reg_ack within 20 cycles at step %0d", i);
        errors++;
        timed_out = 1;
      end else begin
        @(posedge mclk);
        reg_cs <= 1'b0;
        reg_wr <= 1'b0;
        @(negedge mclk);
        checks++;
        assert (reg_ack === 1'b0) else begin
          errors++;
          $display("reg_ack stayed high for a second cycle at step %0d", i);
        end
        if (s.chk[2]) begin
          checks++;
          assert (reg_rdata === s.exp_rdata) else begin
            errors++;
            $display("Mismatch reg_rdata at step %0d: got %h expected %h",
                     i, reg_rdata, s.exp_rdata);
          end
        end
        // Pin select output equals the value read back from its offset
        if (s.chk[2] && !s.wr && (s.addr == glbl_pkg::ADDR_MUX_SEL)) begin
          checks++;
          assert (mux_sel === s.exp_rdata) else begin
            errors++;
            $display("Mismatch mux_sel at step %0d: got %h expected %h",
                     i, mux_sel, s.exp_rdata);
          end
        end
        if (s.chk[1]) begin
          checks++;
          assert (blk_rst_n === s.exp_rst) else begin
            errors++;
            $display("Mismatch blk_rst_n at step %0d: got %h expected %h",
                     i, blk_rst_n, s.exp_rst);
          end
        end
        if (s.chk[0]) begin
          checks++;
          // user_irq, soft_irq, irq_lines
          assert ({user_irq, soft_irq, irq_lines} === s.exp_irq) else begin
            errors++;
            $display("Mismatch {user_irq,soft_irq,irq_lines} at step %0d: got %h expected %h",
                     i, {user_irq, soft_irq, irq_lines}, s.exp_irq);
          end
        end
      end
    end

    $display("Steps: %0d, checks: %0d, errors: %0d", steps.size(), checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
rtl/glbl_pkg.sv
rtl/glbl_bus_if.sv
rtl/glbl_cfg_regs.sv
rtl/glbl_intr_ctrl.sv
rtl/glbl_reg_top.sv
+incdir+verification
verification/tb_glbl_reg.sv
